/* testbench/rvCoreCases.txt */
# P <word index, decimal> <instruction word, hex>
# E <test> <byte address> <data in its lanes> <write mask>
P 0 876540b7 lui x1,0x87654
P 1 32108093 addi x1,x1,0x321
P 2 ff900113 addi x2,x0,-7
P 3 002081b3 add x3,x1,x2
P 4 20302023 sw x3,0x200
P 5 40208233 sub x4,x1,x2
P 6 20402223 sw x4,0x204
P 7 0020a2b3 slt x5,x1,x2
P 8 00113333 sltu x6,x2,x1
P 9 20502423 sw x5,0x208
P 10 20602623 sw x6,0x20c
P 11 0020c3b3 xor x7,x1,x2
P 12 20702823 sw x7,0x210
P 13 0f00f413 andi x8,x1,0xf0
P 14 20802a23 sw x8,0x214
P 15 fff0b493 sltiu x9,x1,-1
P 16 20902c23 sw x9,0x218
P 17 10014513 xori x10,x2,0x100
P 18 20a02e23 sw x10,0x21c
P 19 50546593 ori x11,x8,0x505
P 20 22b02023 sw x11,0x220
P 21 00109613 slli x12,x1,1
P 22 4110d693 srai x13,x1,17
P 23 01f00793 addi x15,x0,31
P 24 00f0d733 srl x14,x1,x15
P 25 40015833 sra x16,x2,x0
P 26 00f118b3 sll x17,x2,x15
P 27 22c02223 sw x12,0x224
P 28 22d02423 sw x13,0x228
P 29 22e02623 sw x14,0x22c
P 30 23002823 sw x16,0x230
P 31 23102a23 sw x17,0x234
P 32 00000a13 addi x20,x0,0
P 33 00628463 beq x5,x6 not taken
P 34 001a0a13 addi x20,x20,1
P 35 00928463 beq x5,x9 taken
P 36 002a0a13 addi x20,x20,2
P 37 00929463 bne x5,x9 not taken
P 38 004a0a13 addi x20,x20,4
P 39 00629463 bne x5,x6 taken
P 40 008a0a13 addi x20,x20,8
P 41 00114463 blt x2,x1 not taken
P 42 010a0a13 addi x20,x20,0x10
P 43 0020c463 blt x1,x2 taken
P 44 020a0a13 addi x20,x20,0x20
P 45 0020d463 bge x1,x2 not taken
P 46 040a0a13 addi x20,x20,0x40
P 47 00115463 bge x2,x1 taken
P 48 080a0a13 addi x20,x20,0x80
P 49 00116463 bltu x2,x1 not taken
P 50 100a0a13 addi x20,x20,0x100
P 51 0020e463 bltu x1,x2 taken
P 52 200a0a13 addi x20,x20,0x200
P 53 0022f463 bgeu x5,x2 not taken
P 54 400a0a13 addi x20,x20,0x400
P 55 00117463 bgeu x2,x1 taken
P 56 800a0a13 addi x20,x20,-2048
P 57 23402c23 sw x20,0x238
P 58 00800aef jal x21,+8
P 59 00000a93 addi x21,x0,0 skipped
P 60 00001b17 auipc x22,0x1
P 61 011a8be7 jalr x23,17(x21)
P 62 00000b93 addi x23,x0,0 skipped
P 63 23502e23 sw x21,0x23c
P 64 25602023 sw x22,0x240
P 65 25702223 sw x23,0x244
P 66 24702423 sw x7,0x248
P 67 24800c03 lb x24,0x248
P 68 25802623 sw x24,0x24c
P 69 24900c03 lb x24,0x249
P 70 25802823 sw x24,0x250
P 71 24a00c03 lb x24,0x24a
P 72 25802a23 sw x24,0x254
P 73 24b00c03 lb x24,0x24b
P 74 25802c23 sw x24,0x258
P 75 24804c03 lbu x24,0x248
P 76 25802e23 sw x24,0x25c
P 77 24904c03 lbu x24,0x249
P 78 27802023 sw x24,0x260
P 79 24a04c03 lbu x24,0x24a
P 80 27802223 sw x24,0x264
P 81 24b04c03 lbu x24,0x24b
P 82 27802423 sw x24,0x268
P 83 24801c03 lh x24,0x248
P 84 27802623 sw x24,0x26c
P 85 24a01c03 lh x24,0x24a
P 86 27802823 sw x24,0x270
P 87 24805c03 lhu x24,0x248
P 88 27802a23 sw x24,0x274
P 89 24a05c03 lhu x24,0x24a
P 90 27802c23 sw x24,0x278
P 91 24802c03 lw x24,0x248
P 92 27802e23 sw x24,0x27c
P 93 28100023 sb x1,0x280
P 94 281000a3 sb x1,0x281
P 95 28100123 sb x1,0x282
P 96 281001a3 sb x1,0x283
P 97 28101223 sh x1,0x284
P 98 28101323 sh x1,0x286
P 99 0e002e23 sw x0,0xfc end marker
P 100 0000006f jal x0,0
E 1 00000200 8765431a f
E 1 00000204 87654328 f
E 1 00000208 00000001 f
E 1 0000020c 00000000 f
E 1 00000210 789abcd8 f
E 1 00000214 00000020 f
E 1 00000218 00000001 f
E 1 0000021c fffffef9 f
E 1 00000220 00000525 f
E 2 00000224 0eca8642 f
E 2 00000228 ffffc3b2 f
E 2 0000022c 00000001 f
E 2 00000230 fffffff9 f
E 2 00000234 80000000 f
E 3 00000238 00000555 f
E 4 0000023c 000000ec f
E 4 00000240 000010f0 f
E 4 00000244 000000f8 f
E 5 00000248 789abcd8 f
E 5 0000024c ffffffd8 f
E 5 00000250 ffffffbc f
E 5 00000254 ffffff9a f
E 5 00000258 00000078 f
E 5 0000025c 000000d8 f
E 5 00000260 000000bc f
E 5 00000264 0000009a f
E 5 00000268 00000078 f
E 5 0000026c ffffbcd8 f
E 5 00000270 0000789a f
E 5 00000274 0000bcd8 f
E 5 00000278 0000789a f
E 5 0000027c 789abcd8 f
E 6 00000280 00000021 1
E 6 00000281 00002100 2
E 6 00000282 00210000 4
E 6 00000283 21000000 8
E 6 00000284 00004321 3
E 6 00000286 43210000 c

/* vlog.f */
hdl/rvCorePkg.sv
hdl/aluIf.sv
hdl/instrDecoder.sv
hdl/registerFile.sv
hdl/serialAlu.sv
hdl/loadStoreUnit.sv
hdl/instrSequencer.sv
hdl/rvCore.sv
testbench/rvCoreTb.sv

/* Makefile */
SRCS := $(wildcard hdl/*.sv) testbench/rvCoreTb.sv

obj_dir/VrvCoreTb: $(SRCS) vlog.f
	verilator --binary -Wno-fatal --top-module rvCoreTb -f vlog.f -Mdir obj_dir

.PHONY: run clean

run: obj_dir/VrvCoreTb testbench/rvCoreCases.txt
	@out="$$(./obj_dir/VrvCoreTb)"; echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir

/* testbench/rvCoreTb.sv */
module rvCoreTb;
   import rvCorePkg::*;

   logic      clk;
   logic      reset;
   word_t     memAddr;
   word_t     memWdata;
   byteMask_t memWmask;
   logic      memRstrb;
   word_t     memRdata;
   logic      memRbusy;
   logic      memWbusy;

   // 256-word memory where byte address bits 9..2 select the word
   word_t mem [0:255];

   // Expected store sequence from the cases file
   int        expTest [$];
   word_t     expAddr [$];
   word_t     expData [$];
   byteMask_t expMask [$];

   int          programWords;
   int          cycleCount;
   int          cycleLimit;
   int          testErrors;
   int          passCount;
   int          failCount;
   int          readBusyLeft;
   int          writeBusyLeft;
   bit          endSeen;
   logic        rstrbLast;
   int unsigned lcgState;

   rvCore rvCore_inst (
      .clk      (clk),
      .reset    (reset),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memWmask (memWmask),
      .memRstrb (memRstrb),
      .memRdata (memRdata),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // LCG step giving 0 to 2 busy cycles from the upper bits
   function automatic int randomBusy();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return int'((lcgState >> 16) % 3);
   endfunction

   // Background fill that differs in every word
   function automatic word_t fillPattern(input logic [7:0] idx);
      return {idx, idx ^ 8'h5a, ~idx, idx + 8'h33};
   endfunction

   // One byte mask bit widened to its 8 data bits
   function automatic word_t laneBits(input byteMask_t mask);
      return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
   endfunction

   task automatic checkWord(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
         testErrors++;
      end
   endtask

   task automatic checkMask(input string name, input byteMask_t got, input byteMask_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
         testErrors++;
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
         testErrors++;
      end
   endtask

   // A read pulse lasts one cycle and never starts while the bus is busy or writing
   task automatic checkReadPulse();
      if (rstrbLast || memRbusy || memWbusy || (memWmask != 4'b0000)) begin
         checkBit("memRstrb", memRstrb, 1'b0);
      end
      rstrbLast = memRstrb;
   endtask

   // Reads P and E lines and skips the comment lines
   task automatic loadCases();
      int        fd;
      int        idx;
      int        test;
      word_t     word;
      word_t     addr;
      byteMask_t mask;
      string     line;
      fd = $fopen("testbench/rvCoreCases.txt", "r");
      if (fd == 0) begin
         $display("Cannot open testbench/rvCoreCases.txt");
         failCount++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if ($sscanf(line, "P %d %h", idx, word) == 2) begin
            mem[idx] = word;
            programWords++;
         end else if ($sscanf(line, "E %d %h %h %h", test, addr, word, mask) == 4) begin
            expTest.push_back(test);
            expAddr.push_back(addr);
            expData.push_back(word);
            expMask.push_back(mask);
         end
      end
      $fclose(fd);
   endtask

   // Checks one write pulse against the next expected store
   task automatic handleWrite();
      int        test;
      word_t     addr;
      word_t     data;
      byteMask_t mask;
      word_t     lanes;
      if (memAddr == 32'h0000_00fc) begin
         // End marker of the program
         endSeen = 1'b1;
      end else if (expTest.size() == 0) begin
         $display("Unexpected store at %0t to address %h with data %h, none was left",
                  $time, memAddr, memWdata);
         failCount++;
      end else begin
         test  = expTest.pop_front();
         addr  = expAddr.pop_front();
         data  = expData.pop_front();
         mask  = expMask.pop_front();
         // Only the written lanes carry defined data
         lanes = laneBits(mask);
         checkWord("memAddr", memAddr, addr);
         checkWord("memWdata", memWdata & lanes, data & lanes);
         checkMask("memWmask", memWmask, mask);
         // Last store of this test
         if (expTest.size() == 0 || expTest[0] != test) begin
            $display("Test %0d finished with %0d errors", test, testErrors);
            if (testErrors == 0) begin
               passCount++;
            end else begin
               failCount++;
            end
            testErrors = 0;
         end
      end
      for (int l = 0; l < 4; l++) begin
         if (memWmask[l]) begin
            mem[memAddr[9:2]][8*l +: 8] = memWdata[8*l +: 8];
         end
      end
   endtask

   // Memory model driving all inputs on the falling edge
   always @(negedge clk) begin
      if (reset) begin
         checkReadPulse();
         if (readBusyLeft > 0) begin
            readBusyLeft--;
         end
         if (writeBusyLeft > 0) begin
            writeBusyLeft--;
         end
         if (memRstrb === 1'b1) begin
            // Data held from the pulse on while busy only delays acceptance
            memRdata     = mem[memAddr[9:2]];
            readBusyLeft = randomBusy();
         end
         if (memWmask !== 4'b0000 && !$isunknown(memWmask)) begin
            handleWrite();
            writeBusyLeft = randomBusy();
         end
         memRbusy = (readBusyLeft > 0);
         memWbusy = (writeBusyLeft > 0);
      end
   end

   initial begin
      reset         = 1'b0;
      memRdata      = '0;
      memRbusy      = 1'b0;
      memWbusy      = 1'b0;
      lcgState      = 32'hbc77;
      programWords  = 0;
      cycleCount    = 0;
      testErrors    = 0;
      passCount     = 0;
      failCount     = 0;
      readBusyLeft  = 0;
      writeBusyLeft = 0;
      endSeen       = 1'b0;
      rstrbLast     = 1'b0;
      for (int i = 0; i < 256; i++) begin
         mem[i] = fillPattern(i[7:0]);
      end
      loadCases();
      cycleLimit = 64 * programWords + 200;

      // Two cycles of reset released on a falling edge
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;

      while (!endSeen && cycleCount < cycleLimit) begin
         @(posedge clk);
         cycleCount++;
      end

      if (!endSeen) begin
         $display("Timeout after %0d cycles, the program never reached its final store",
                  cycleCount);
         failCount++;
      end else if (expTest.size() != 0) begin
         $display("Program ended with %0d expected stores missing, first from test %0d",
                  expTest.size(), expTest[0]);
         failCount++;
      end

      // Errors seen after the last finished test
      if (testErrors != 0) begin
         $display("Found %0d errors after the last finished test", testErrors);
         failCount++;
      end

      $display("Tests passed %0d, failed %0d", passCount, failCount);
      if (failCount == 0 && passCount > 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* hdl/rvCore.sv */
module rvCore (
   input  logic                 clk,
   input  logic                 reset,
   output rvCorePkg::word_t     memAddr,
   output rvCorePkg::word_t     memWdata,
   output rvCorePkg::byteMask_t memWmask,
   output logic                 memRstrb,
   input  rvCorePkg::word_t     memRdata,
   input  logic                 memRbusy,
   input  logic                 memWbusy
);
   import rvCorePkg::*;

   decodedInstr_t decoded;
   word_t         instrLatch;
   logic          capture;
   word_t         rs1;
   word_t         rs2;
   word_t         loadData;
   byteMask_t     storeMask;
   addr_t         loadStoreAddr;
   logic          writeEnable;
   word_t         writeData;

   // Sequencer to ALU
   aluIf aluBus ();

   instrDecoder instrDecoder_inst (
      .instr   (instrLatch),
      .decoded (decoded)
   );

   // Operands are read straight from the fetched word
   registerFile registerFile_inst (
      .clk         (clk),
      .capture     (capture),
      .instrWord   (memRdata),
      .writeEnable (writeEnable),
      .rdId        (decoded.rdId),
      .writeData   (writeData),
      .rs1         (rs1),
      .rs2         (rs2)
   );

   serialAlu serialAlu_inst (
      .clk (clk),
      .bus (aluBus.alu)
   );

   loadStoreUnit loadStoreUnit_inst (
      .decoded   (decoded),
      .byteAddr  (loadStoreAddr[1:0]),
      .rs2       (rs2),
      .memRdata  (memRdata),
      .loadData  (loadData),
      .storeData (memWdata),
      .storeMask (storeMask)
   );

   instrSequencer instrSequencer_inst (
      .clk           (clk),
      .reset         (reset),
      .decoded       (decoded),
      .rs1           (rs1),
      .rs2           (rs2),
      .memRdata      (memRdata),
      .loadData      (loadData),
      .storeMask     (storeMask),
      .memRbusy      (memRbusy),
      .memWbusy      (memWbusy),
      .alu           (aluBus.ctrl),
      .instrLatch    (instrLatch),
      .capture       (capture),
      .loadStoreAddr (loadStoreAddr),
      .memAddr       (memAddr),
      .memRstrb      (memRstrb),
      .memWmask      (memWmask),
      .writeEnable   (writeEnable),
      .writeData     (writeData)
   );

endmodule

/* hdl/instrSequencer.sv */
module instrSequencer (
   input  logic                     clk,
   input  logic                     reset,
   input  rvCorePkg::decodedInstr_t decoded,
   input  rvCorePkg::word_t         rs1,
   input  rvCorePkg::word_t         rs2,
   input  rvCorePkg::word_t         memRdata,
   input  rvCorePkg::word_t         loadData,
   input  rvCorePkg::byteMask_t     storeMask,
   input  logic                     memRbusy,
   input  logic                     memWbusy,
   aluIf.ctrl                       alu,
   output rvCorePkg::word_t         instrLatch,
   output logic                     capture,
   output rvCorePkg::addr_t         loadStoreAddr,
   output rvCorePkg::word_t         memAddr,
   output logic                     memRstrb,
   output rvCorePkg::byteMask_t     memWmask,
   output logic                     writeEnable,
   output rvCorePkg::word_t         writeData
);
   import rvCorePkg::*;

   seqState_t state;
   addr_t     pc;
   addr_t     pcPlus4;
   addr_t     pcPlusImm;
   addr_t     pcImm;
   logic      predicate;
   logic      isAlu;
   logic      needToWait;
   logic      branchTaken;

   assign isAlu   = decoded.isAluImm | decoded.isAluReg;
   assign pcPlus4 = pc + addr_t'(4);

   // Operand two is rs2 for register ops and branches and the I immediate otherwise
   assign alu.in1      = rs1;
   assign alu.in2      = (decoded.isAluReg | decoded.isBranch) ? rs2 : decoded.iImm;
   assign alu.funct3Is = decoded.funct3Is;
   assign alu.altFunct = decoded.altFunct;
   assign alu.regForm  = decoded.regForm;
   // Result register loads once per ALU instruction
   assign alu.start    = (state == EXECUTE1) & isAlu;

   // Branch condition sampled in EXECUTE1
   assign branchTaken = decoded.funct3Is[0] &  alu.eq  |
                        decoded.funct3Is[1] & ~alu.eq  |
                        decoded.funct3Is[4] &  alu.lt  |
                        decoded.funct3Is[5] & ~alu.lt  |
                        decoded.funct3Is[6] &  alu.ltu |
                        decoded.funct3Is[7] & ~alu.ltu;

   // Offset for JAL, AUIPC or a branch
   assign pcImm = decoded.isJal   ? decoded.jImm[ADDR_WIDTH-1:0] :
                  decoded.isAuipc ? decoded.uImm[ADDR_WIDTH-1:0] :
                                    decoded.bImm[ADDR_WIDTH-1:0];

   assign needToWait = decoded.isLoad | decoded.isStore | isAlu;

   // Instruction word accepted from the bus
   assign capture = (state == WAIT_INSTR) & ~memRbusy;

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Wait for any pending write before the first fetch
         state <= WAIT_ALU_OR_MEM;
         pc    <= RESET_ADDR;
      end else begin
         case (state)
            FETCH_INSTR: begin
               state <= WAIT_INSTR;
            end
            WAIT_INSTR: begin
               if (!memRbusy) begin
                  state <= EXECUTE1;
               end
            end
            EXECUTE1: begin
               state <= EXECUTE2;
            end
            EXECUTE2: begin
               // JALR clears bit 0 of its target
               if (decoded.isJalr) begin
                  pc <= {alu.sum[ADDR_WIDTH-1:1], 1'b0};
               end else if (decoded.isJal | (decoded.isBranch & predicate)) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               state <= needToWait ? WAIT_ALU_OR_MEM : FETCH_INSTR;
            end
            WAIT_ALU_OR_MEM: begin
               if (!alu.busy && !memRbusy && !memWbusy) begin
                  state <= FETCH_INSTR;
               end
            end
            default: begin
               state <= WAIT_ALU_OR_MEM;
            end
         endcase
      end
   end

   // Instruction latch and EXECUTE1 results
   always_ff @(posedge clk) begin
      if (capture) begin
         instrLatch <= memRdata;
      end
      if (state == EXECUTE1) begin
         pcPlusImm     <= pc + pcImm;
         // Stores use the S immediate and loads the I immediate
         loadStoreAddr <= rs1[ADDR_WIDTH-1:0] + (decoded.isStore ?
                          decoded.sImm[ADDR_WIDTH-1:0] : decoded.iImm[ADDR_WIDTH-1:0]);
         predicate     <= branchTaken;
      end
   end

   // PC during fetch and the data address otherwise
   assign memAddr = {{(XLEN-ADDR_WIDTH){1'b0}},
                     ((state == FETCH_INSTR) | (state == WAIT_INSTR)) ? pc : loadStoreAddr};

   // Read pulse for fetch and for loads
   assign memRstrb = (state == FETCH_INSTR) | ((state == EXECUTE2) & decoded.isLoad);
   assign memWmask = {4{(state == EXECUTE2) & decoded.isStore}} & storeMask;

   // Write-back in EXECUTE2 and on every wait cycle where the last one wins
   assign writeEnable = ~(decoded.isBranch | decoded.isStore) &
                        ((state == EXECUTE2) | (state == WAIT_ALU_OR_MEM));

   always_comb begin
      writeData = '0;
      if (decoded.isLui) begin
         writeData = decoded.uImm;
      end else if (isAlu) begin
         writeData = alu.result;
      end else if (decoded.isAuipc) begin
         writeData = {{(XLEN-ADDR_WIDTH){1'b0}}, pcPlusImm};
      end else if (decoded.isJal | decoded.isJalr) begin
         writeData = {{(XLEN-ADDR_WIDTH){1'b0}}, pcPlus4};
      end else if (decoded.isLoad) begin
         writeData = loadData;
      end
   end

endmodule

/* hdl/loadStoreUnit.sv */
module loadStoreUnit (
   input  rvCorePkg::decodedInstr_t decoded,
   input  logic [1:0]               byteAddr,
   input  rvCorePkg::word_t         rs2,
   input  rvCorePkg::word_t         memRdata,
   output rvCorePkg::word_t         loadData,
   output rvCorePkg::word_t         storeData,
   output rvCorePkg::byteMask_t     storeMask
);
   import rvCorePkg::*;

   logic        byteAccess;
   logic        halfAccess;
   logic        loadUnsigned;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign byteAccess = (decoded.accessSize == 2'b00);
   assign halfAccess = (decoded.accessSize == 2'b01);

   // LBU and LHU are funct3 100 and 101
   assign loadUnsigned = decoded.funct3Is[4] | decoded.funct3Is[5];

   // Address bit 1 picks the halfword, bit 0 the byte inside it
   assign loadHalf = byteAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = byteAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   // Fill bit for the upper part of a sub-word load
   assign loadSign = ~loadUnsigned & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

   // Store data replicated so the addressed lanes carry it
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = byteAddr[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = byteAddr[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = byteAddr[0] ? rs2[7:0] :
                             byteAddr[1] ? rs2[15:8] : rs2[31:24];

   // Lane mask
   // one lane for bytes, two for halfwords, all four for words
   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << byteAddr;
      end else if (halfAccess) begin
         storeMask = byteAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

endmodule

/* hdl/serialAlu.sv */
module serialAlu (
   input logic clk,
   aluIf.alu   bus
);
   import rvCorePkg::*;

   word_t       aluReg;
   logic [4:0]  shamt;
   logic [32:0] aluMinus;
   logic        isShift;
   logic        doSub;
   word_t       opResult;

   // Adder shared by ADD/ADDI and the JALR target
   assign bus.sum = bus.in1 + bus.in2;

   // One 33-bit subtract serves SUB and every compare
   assign aluMinus = {1'b1, ~bus.in2} + {1'b0, bus.in1} + 33'd1;
   assign bus.ltu  = aluMinus[32];
   // Signs differ, so in1 is less exactly when it is negative
   assign bus.lt   = (bus.in1[31] ^ bus.in2[31]) ? bus.in1[31] : aluMinus[32];
   assign bus.eq   = (aluMinus[31:0] == '0);

   // SLL is funct3 001, SRL/SRA is 101
   assign isShift = bus.funct3Is[1] | bus.funct3Is[5];

   // ADDI has bit 30 in its immediate, so bit 5 must qualify SUB
   assign doSub = bus.altFunct & bus.regForm;

   // Single-cycle results, one-hot select by funct3
   always_comb begin
      opResult = '0;
      if (isShift) begin
         opResult = bus.in1;
      end
      if (bus.funct3Is[0]) begin
         opResult = doSub ? aluMinus[31:0] : bus.sum;
      end
      if (bus.funct3Is[2]) begin
         opResult = {31'b0, bus.lt};
      end
      if (bus.funct3Is[3]) begin
         opResult = {31'b0, bus.ltu};
      end
      if (bus.funct3Is[4]) begin
         opResult = bus.in1 ^ bus.in2;
      end
      if (bus.funct3Is[6]) begin
         opResult = bus.in1 | bus.in2;
      end
      if (bus.funct3Is[7]) begin
         opResult = bus.in1 & bus.in2;
      end
   end

   always_ff @(posedge clk) begin
      if (bus.start) begin
         // Shifts start from the operand and run shamt cycles
         shamt  <= isShift ? bus.in2[4:0] : 5'd0;
         aluReg <= opResult;
      end else if (shamt != 5'd0) begin
         shamt <= shamt - 5'd1;
         // One bit per cycle, sign fill only for SRA
         aluReg <= bus.funct3Is[1] ? {aluReg[30:0], 1'b0}
                                   : {bus.altFunct & aluReg[31], aluReg[31:1]};
      end
   end

   assign bus.result = aluReg;
   assign bus.busy   = (shamt != 5'd0);

endmodule

/* hdl/registerFile.sv */
module registerFile (
   input  logic              clk,
   input  logic              capture,
   input  rvCorePkg::word_t  instrWord,
   input  logic              writeEnable,
   input  rvCorePkg::regId_t rdId,
   input  rvCorePkg::word_t  writeData,
   output rvCorePkg::word_t  rs1,
   output rvCorePkg::word_t  rs2
);
   import rvCorePkg::*;

   // x0 has no storage, it always reads as zero
   word_t  regs [1:31];
   regId_t rs1Id;
   regId_t rs2Id;

   // Source fields of the arriving instruction
   assign rs1Id = instrWord[19:15];
   assign rs2Id = instrWord[24:20];

   always_ff @(posedge clk) begin
      if (writeEnable && (rdId != 5'd0)) begin
         regs[rdId] <= writeData;
      end
      // Operands read while the instruction word is on the bus
      if (capture) begin
         rs1 <= (rs1Id == 5'd0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == 5'd0) ? '0 : regs[rs2Id];
      end
   end

endmodule

/* hdl/instrDecoder.sv */
module instrDecoder (
   input  rvCorePkg::word_t         instr,
   output rvCorePkg::decodedInstr_t decoded
);
   import rvCorePkg::*;

   logic [4:0] opcode;

   // Bits 1 and 0 are always 11 in RV32I, so only 6..2 matter
   assign opcode = instr[6:2];

   // Opcode classes
   assign decoded.isLoad   = (opcode == OP_LOAD);
   assign decoded.isAluImm = (opcode == OP_ALUIMM);
   assign decoded.isAuipc  = (opcode == OP_AUIPC);
   assign decoded.isStore  = (opcode == OP_STORE);
   assign decoded.isAluReg = (opcode == OP_ALUREG);
   assign decoded.isLui    = (opcode == OP_LUI);
   assign decoded.isBranch = (opcode == OP_BRANCH);
   assign decoded.isJalr   = (opcode == OP_JALR);
   assign decoded.isJal    = (opcode == OP_JAL);

   // Destination register
   assign decoded.rdId = instr[11:7];

   // funct3 expanded to one-hot
   assign decoded.funct3Is = 8'b0000_0001 << instr[14:12];

   // Low funct3 bits give load/store size
   assign decoded.accessSize = instr[13:12];

   // SUB/SRA flag and the register-form bit
   assign decoded.altFunct = instr[30];
   assign decoded.regForm  = instr[5];

   // Upper immediate, LUI and AUIPC
   assign decoded.uImm = {instr[31:12], 12'b0};

   // Short immediate, ALU immediates, loads and JALR
   assign decoded.iImm = {{21{instr[31]}}, instr[30:20]};

   // Stores split the immediate around rd
   assign decoded.sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};

   // Branch offset, always even
   assign decoded.bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

   // Jump offset, also even
   assign decoded.jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

/* hdl/aluIf.sv */
interface aluIf;
   import rvCorePkg::*;

   // Operands and operation select from the sequencer
   word_t         in1;
   word_t         in2;
   logic          start;
   funct3OneHot_t funct3Is;
   logic          altFunct;
   logic          regForm;

   // Registered result, busy while a shift is running
   word_t         result;
   logic          busy;

   // Combinational sum and compares, used for JALR and branches
   word_t         sum;
   logic          eq;
   logic          lt;
   logic          ltu;

   modport ctrl (
      output in1, in2, start, funct3Is, altFunct, regForm,
      input  result, busy, sum, eq, lt, ltu
   );

   modport alu (
      input  in1, in2, start, funct3Is, altFunct, regForm,
      output result, busy, sum, eq, lt, ltu
   );

endinterface

/* hdl/rvCorePkg.sv */
package rvCorePkg;

   // Data word and internal address widths
   localparam int XLEN       = 32;
   localparam int ADDR_WIDTH = 24;

   // First fetch address after reset
   localparam logic [ADDR_WIDTH-1:0] RESET_ADDR = '0;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [4:0]            regId_t;
   typedef logic [3:0]            byteMask_t;

   // Bit n set when funct3 equals n
   typedef logic [7:0] funct3OneHot_t;

   // Major opcodes, instruction bits 6 to 2
   localparam logic [4:0] OP_LOAD   = 5'b00000;
   localparam logic [4:0] OP_ALUIMM = 5'b00100;
   localparam logic [4:0] OP_AUIPC  = 5'b00101;
   localparam logic [4:0] OP_STORE  = 5'b01000;
   localparam logic [4:0] OP_ALUREG = 5'b01100;
   localparam logic [4:0] OP_LUI    = 5'b01101;
   localparam logic [4:0] OP_BRANCH = 5'b11000;
   localparam logic [4:0] OP_JALR   = 5'b11001;
   localparam logic [4:0] OP_JAL    = 5'b11011;

   // Sequencer states, one bit per state
   typedef enum logic [4:0] {
      FETCH_INSTR     = 5'b00001,
      WAIT_INSTR      = 5'b00010,
      EXECUTE1        = 5'b00100,
      EXECUTE2        = 5'b01000,
      WAIT_ALU_OR_MEM = 5'b10000
   } seqState_t;

   // Everything the datapath needs from one instruction
   typedef struct packed {
      logic isLoad;
      logic isAluImm;
      logic isAuipc;
      logic isStore;
      logic isAluReg;
      logic isLui;
      logic isBranch;
      logic isJalr;
      logic isJal;
      regId_t rdId;
      funct3OneHot_t funct3Is;
      // funct3 bits 1 and 0, 00 byte, 01 halfword, 10 word
      logic [1:0] accessSize;
      // Instruction bit 30, SUB and SRA select
      logic altFunct;
      // Instruction bit 5, separates register form from immediate form
      logic regForm;
      word_t uImm;
      word_t iImm;
      word_t sImm;
      word_t bImm;
      word_t jImm;
   } decodedInstr_t;

endpackage
